/* compile.f */
source/video_pkg.sv
source/apb_ctrl_regs.sv
source/pal_line_capture.sv
source/line_buffer.sv
source/vga_line_scanner.sv
source/scandoubler_top.sv
tb/scandoubler_sva.sv
tb/tb_scandoubler.sv

/* Makefile */
# Verilator simulation of the scandoubler testbench
VERILATOR ?= verilator
TOP       ?= tb_scandoubler
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_scandoubler.sv */
`timescale 1ns/10ps

module tb_scandoubler;
    import video_pkg::*;

    localparam int LINE_PIXELS   = 32;
    localparam int VGA_HSYNC     = 4;
    localparam int APB_TIMEOUT   = 16;
    localparam int DRAIN_TIMEOUT = 1000;

    // DUT ports
    logic       clk24;
    logic       reset;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       pixel_ce;
    rgb_pixel_t pixel;
    logic       hsync_n;
    logic       vsync_n;
    rgb_pixel_t pixel_out;
    logic       out_valid;
    logic       hsync;
    logic       vsync;

    // Reference model state
    integer     seed;
    rgb_pixel_t exp_q[$];
    rgb_pixel_t exp_pix;
    logic       model_scandouble;
    logic       model_effect;
    int         lines_sent;
    int         bypass_lines;
    int         sd_lines;

    // Monitor state
    logic       reset_q;
    logic       hsync_n_q;
    logic       vsync_n_q;
    logic       hsync_prev;
    int         hsync_len;
    int         hsync_pulses;
    int         exp_width;
    int         pixels_checked;

    scandoubler_top #(
        .LINE_PIXELS (LINE_PIXELS),
        .VGA_HSYNC   (VGA_HSYNC)
    ) DUT (
        .clk24     (clk24),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pixel_ce  (pixel_ce),
        .pixel     (pixel),
        .hsync_n   (hsync_n),
        .vsync_n   (vsync_n),
        .pixel_out (pixel_out),
        .out_valid (out_valid),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    always #5 clk24 = ~clk24;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic rgb_pixel_t random_pixel();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[8:0];
    endfunction

    // Scanline effect, each channel shifted right by one
    function automatic rgb_pixel_t halve_pixel(input rgb_pixel_t p);
        rgb_pixel_t h;
        h.r = p.r >> 1;
        h.g = p.g >> 1;
        h.b = p.b >> 1;
        return h;
    endfunction

    // One APB transfer, setup then access until pready
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        @(negedge clk24);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk24);
        apb_req.penable = 1'b1;
        waited = 0;
        while (!apb_rsp.pready) begin
            if (waited == APB_TIMEOUT) fail_now("APB slave never raised pready");
            @(negedge clk24);
            waited++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk24);
        apb_req = '0;
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [31:0] expected,
                              input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, '0, rdata, err);
        assert (err == exp_err)
            else fail_now($sformatf("Fail pslverr: got %h, expected %h", err, exp_err));
        // Data only defined on a good read
        if (!exp_err) begin
            assert (rdata == expected)
                else fail_now($sformatf("Fail prdata: got %h, expected %h", rdata, expected));
        end
    endtask

    task automatic check_write(input logic [3:0] addr, input logic [31:0] data,
                               input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        assert (err == exp_err)
            else fail_now($sformatf("Fail pslverr: got %h, expected %h", err, exp_err));
    endtask

    //////////////////////////////////////////////////
    // Video stimulus
    //////////////////////////////////////////////////

    // One clock of video inputs, bypass expects every enabled sample
    task automatic drive_clock(input logic ce, input logic hs_n, input logic vs_n,
                               input rgb_pixel_t pix);
        @(negedge clk24);
        pixel_ce = ce;
        hsync_n  = hs_n;
        vsync_n  = vs_n;
        pixel    = pix;
        if (ce && !model_scandouble) exp_q.push_back(pix);
    endtask

    // Pixel period is two clocks, enable on the first
    task automatic drive_pixel(input logic hs_n, input logic vs_n, input rgb_pixel_t pix);
        drive_clock(1'b1, hs_n, vs_n, pix);
        drive_clock(1'b0, hs_n, vs_n, pix);
    endtask

    task automatic send_line(input logic frame_start);
        rgb_pixel_t line_pix [LINE_PIXELS+4];
        int         i;
        for (i = 0; i < LINE_PIXELS + 4; i++) line_pix[i] = random_pixel();
        // Two copies of the stored part, extra pixels never shown
        if (model_scandouble) begin
            for (i = 0; i < LINE_PIXELS; i++) exp_q.push_back(line_pix[i]);
            for (i = 0; i < LINE_PIXELS; i++) begin
                exp_q.push_back(model_effect ? halve_pixel(line_pix[i]) : line_pix[i]);
            end
            sd_lines++;
        end else begin
            bypass_lines++;
        end
        lines_sent++;
        // Sync, then active pixels
        for (i = 0; i < VGA_HSYNC + 2; i++) drive_pixel(1'b0, !frame_start, random_pixel());
        for (i = 0; i < LINE_PIXELS + 4; i++) drive_pixel(1'b1, !frame_start, line_pix[i]);
    endtask

    task automatic idle_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) drive_clock(1'b0, 1'b1, 1'b1, '0);
    endtask

    task automatic wait_for_output_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) fail_now("timeout waiting for expected pixels");
            @(negedge clk24);
            waited++;
        end
    endtask

    task automatic run_lines(input int n);
        int i;
        for (i = 0; i < n; i++) send_line(i == 0);
        idle_cycles(2);
        wait_for_output_drain();
        idle_cycles(4);
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    // Inputs as seen by the DUT at the clock edge
    always @(posedge clk24) begin
        reset_q   <= reset;
        hsync_n_q <= hsync_n;
        vsync_n_q <= vsync_n;
    end

    always @(negedge clk24) begin
        if (!reset_q) begin
            if (out_valid) begin
                assert (exp_q.size() > 0)
                    else fail_now("output pixel seen with no expected pixel left");
                exp_pix = exp_q.pop_front();
                assert (pixel_out == exp_pix)
                    else fail_now($sformatf("Fail pixel_out: got %h, expected %h",
                                            pixel_out, exp_pix));
                pixels_checked++;
            end
            assert (vsync == !vsync_n_q)
                else fail_now($sformatf("Fail vsync: got %h, expected %h", vsync, !vsync_n_q));
            // Bypass hsync mirrors the input one clock later
            if (!model_scandouble) begin
                assert (hsync == !hsync_n_q)
                    else fail_now($sformatf("Fail hsync: got %h, expected %h",
                                            hsync, !hsync_n_q));
            end
            if (hsync && !hsync_prev) hsync_pulses++;
            if (hsync) begin
                hsync_len++;
            end else if (hsync_prev) begin
                exp_width = model_scandouble ? VGA_HSYNC : 2 * (VGA_HSYNC + 2);
                assert (hsync_len == exp_width)
                    else fail_now($sformatf("Fail hsync width: got %h, expected %h",
                                            hsync_len, exp_width));
                hsync_len = 0;
            end
            hsync_prev = hsync;
            assert (DUT.u_scanner.u_sva.fail_count == 0)
                else fail_now("a bound scanner assertion failed");
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        seed             = 32'h2cce;
        clk24            = 1'b0;
        reset            = 1'b1;
        apb_req          = '0;
        pixel_ce         = 1'b0;
        pixel            = '0;
        hsync_n          = 1'b1;
        vsync_n          = 1'b1;
        model_scandouble = 1'b0;
        model_effect     = 1'b1;
        lines_sent       = 0;
        bypass_lines     = 0;
        sd_lines         = 0;
        hsync_prev       = 1'b0;
        hsync_len        = 0;
        hsync_pulses     = 0;
        pixels_checked   = 0;
        repeat (3) @(negedge clk24);
        reset = 1'b0;

        // Reset values
        check_read(REG_CTRL, 32'd0, 1'b0);
        check_read(REG_LINES, 32'd0, 1'b0);

        // Bypass
        run_lines(4);
        check_read(REG_LINES, 32'(lines_sent), 1'b0);

        // Scandoubling, effect on
        check_write(REG_CTRL, 32'd1, 1'b0);
        model_scandouble = 1'b1;
        model_effect     = 1'b1;
        check_read(REG_CTRL, 32'd1, 1'b0);
        run_lines(5);

        // Scandoubling, effect off
        check_write(REG_CTRL, 32'd3, 1'b0);
        model_effect = 1'b0;
        check_read(REG_CTRL, 32'd3, 1'b0);
        run_lines(5);
        check_read(REG_LINES, 32'(lines_sent), 1'b0);

        // Error responses, counter unchanged by the write
        check_write(REG_LINES, 32'h0000_00ff, 1'b1);
        check_write(4'd8, 32'd1, 1'b1);
        check_read(4'd12, 32'd0, 1'b1);
        check_read(REG_LINES, 32'(lines_sent), 1'b0);

        // Back to bypass
        check_write(REG_CTRL, 32'd0, 1'b0);
        model_scandouble = 1'b0;
        model_effect     = 1'b1;
        run_lines(3);
        check_read(REG_LINES, 32'(lines_sent), 1'b0);

        // One pulse per bypass line, two per scandoubled line
        assert (hsync_pulses == bypass_lines + 2 * sd_lines)
            else fail_now($sformatf("Fail hsync pulse count: got %h, expected %h",
                                    hsync_pulses, bypass_lines + 2 * sd_lines));
        if (DUT.u_scanner.u_sva.fail_count == 0 && pixels_checked > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_now("bound assertion errors or no pixels checked");
        end
    end

endmodule

/* tb/scandoubler_sva.sv */
`timescale 1ns/10ps

module scandoubler_sva #(
    parameter int LINE_PIXELS = 32
) (
    input logic                           clk24,
    input logic                           reset,
    input logic                           scan_enable,
    input logic                           line_done,
    input video_pkg::scan_state_e         state,
    input logic                           in_active,
    input logic                           last,
    input logic                           hsync,
    input logic                           out_valid,
    input logic [$clog2(LINE_PIXELS)-1:0] rd_addr
);
    import video_pkg::*;

    localparam int ADDR_W = $clog2(LINE_PIXELS);

    // Number of failed assertions, watched by the testbench
    int                fail_count = 0;
    logic [ADDR_W-1:0] next_addr;

    assign next_addr = rd_addr + ADDR_W'(1);

    // New line only when the replay is finished
    no_overrun: assert property (@(posedge clk24) disable iff (reset)
        line_done |-> state == IDLE)
        else begin
            fail_count = fail_count + 1;
            $error("line_done while the scanner is busy");
        end

    // Blanking during VGA hsync, the active part follows it directly
    no_valid_in_sync: assert property (@(posedge clk24) disable iff (reset || !scan_enable)
        hsync |-> !out_valid ##1 (hsync || out_valid))
        else begin
            fail_count = fail_count + 1;
            $error("out_valid high during scandoubled hsync or gap after it");
        end

    // Read address steps by one through the active part
    addr_sequence: assert property (@(posedge clk24) disable iff (reset || !scan_enable)
        in_active && !last |=> in_active && rd_addr == $past(next_addr))
        else begin
            fail_count = fail_count + 1;
            $error("buffer read address out of sequence");
        end

endmodule

bind vga_line_scanner scandoubler_sva #(
    .LINE_PIXELS (LINE_PIXELS)
) u_sva (
    .clk24       (clk24),
    .reset       (reset),
    .scan_enable (scan_enable),
    .line_done   (line_done),
    .state       (state),
    .in_active   (in_active),
    .last        (last),
    .hsync       (hsync),
    .out_valid   (out_valid),
    .rd_addr     (rd_addr)
);

/* source/scandoubler_top.sv */
`timescale 1ns/10ps

module scandoubler_top #(
    parameter int LINE_PIXELS = 32,
    parameter int VGA_HSYNC   = 4
) (
    input  logic                  clk24,
    input  logic                  reset,
    input  video_pkg::apb_req_t   apb_req,
    output video_pkg::apb_rsp_t   apb_rsp,
    input  logic                  pixel_ce,
    input  video_pkg::rgb_pixel_t pixel,
    input  logic                  hsync_n,
    input  logic                  vsync_n,
    output video_pkg::rgb_pixel_t pixel_out,
    output logic                  out_valid,
    output logic                  hsync,
    output logic                  vsync
);
    import video_pkg::*;

    localparam int ADDR_W = $clog2(LINE_PIXELS);

    // Control
    logic              scan_enable;
    logic              scan_effect;
    logic              line_done;

    // Capture to buffer
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    rgb_pixel_t        wr_pixel;

    // Buffer to scanner
    logic [ADDR_W-1:0] rd_addr;
    rgb_pixel_t        rd_pixel;

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    apb_ctrl_regs u_regs (
        .clk24       (clk24),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .line_done   (line_done),
        .scan_enable (scan_enable),
        .scan_effect (scan_effect)
    );

    //////////////////////////////////////////////////
    // Video path
    //////////////////////////////////////////////////

    pal_line_capture #(
        .LINE_PIXELS (LINE_PIXELS),
        .VGA_HSYNC   (VGA_HSYNC)
    ) u_capture (
        .clk24     (clk24),
        .reset     (reset),
        .pixel_ce  (pixel_ce),
        .hsync_n   (hsync_n),
        .pixel     (pixel),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_pixel  (wr_pixel),
        .line_done (line_done)
    );

    line_buffer #(
        .LINE_PIXELS (LINE_PIXELS)
    ) u_buffer (
        .clk24     (clk24),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_pixel  (wr_pixel),
        .line_done (line_done),
        .rd_addr   (rd_addr),
        .rd_pixel  (rd_pixel)
    );

    vga_line_scanner #(
        .LINE_PIXELS (LINE_PIXELS),
        .VGA_HSYNC   (VGA_HSYNC)
    ) u_scanner (
        .clk24       (clk24),
        .reset       (reset),
        .scan_enable (scan_enable),
        .scan_effect (scan_effect),
        .line_done   (line_done),
        .rd_pixel    (rd_pixel),
        .pixel_ce    (pixel_ce),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .pixel       (pixel),
        .rd_addr     (rd_addr),
        .pixel_out   (pixel_out),
        .out_valid   (out_valid),
        .hsync       (hsync),
        .vsync       (vsync)
    );

endmodule

/* source/vga_line_scanner.sv */
`timescale 1ns/10ps

module vga_line_scanner #(
    parameter int LINE_PIXELS = 32,
    parameter int VGA_HSYNC   = 4
) (
    input  logic                           clk24,
    input  logic                           reset,
    input  logic                           scan_enable,
    input  logic                           scan_effect,
    input  logic                           line_done,
    input  video_pkg::rgb_pixel_t          rd_pixel,
    input  logic                           pixel_ce,
    input  logic                           hsync_n,
    input  logic                           vsync_n,
    input  video_pkg::rgb_pixel_t          pixel,
    output logic [$clog2(LINE_PIXELS)-1:0] rd_addr,
    output video_pkg::rgb_pixel_t          pixel_out,
    output logic                           out_valid,
    output logic                           hsync,
    output logic                           vsync
);
    import video_pkg::*;

    localparam int ADDR_W  = $clog2(LINE_PIXELS);
    localparam int MAX_CNT = (LINE_PIXELS > VGA_HSYNC) ? LINE_PIXELS : VGA_HSYNC;
    localparam int CNT_W   = $clog2(MAX_CNT);

    scan_state_e      state;
    logic [CNT_W-1:0] count;
    logic             in_sync;
    logic             in_active;
    logic             last;
    rgb_pixel_t       halved;

    // Bypass path registers
    rgb_pixel_t       byp_pixel;
    logic             byp_valid;
    logic             byp_hsync;

    //////////////////////////////////////////////////
    // Replay FSM
    //////////////////////////////////////////////////

    assign in_sync   = (state == HSYNC_PASS0) || (state == HSYNC_PASS1);
    assign in_active = (state == ACTIVE_PASS0) || (state == ACTIVE_PASS1);

    // End of the current phase
    assign last = (in_sync && count == CNT_W'(VGA_HSYNC - 1))
               || (in_active && count == CNT_W'(LINE_PIXELS - 1));

    always_ff @(posedge clk24) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
        end else if (!scan_enable) begin
            // Bypass, hold FSM in IDLE
            state <= IDLE;
            count <= '0;
        end else begin
            count <= last ? '0 : count + 1'b1;
            case (state)
                IDLE: begin
                    count <= '0;
                    if (line_done) state <= HSYNC_PASS0;
                end
                HSYNC_PASS0:  if (last) state <= ACTIVE_PASS0;
                ACTIVE_PASS0: if (last) state <= HSYNC_PASS1;
                HSYNC_PASS1:  if (last) state <= ACTIVE_PASS1;
                ACTIVE_PASS1: if (last) state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    // Address one ahead of the output, buffer read takes a cycle
    // During hsync, point at pixel 0
    assign rd_addr = in_active ? count[ADDR_W-1:0] + ADDR_W'(1) : '0;

    // Scanline effect, each channel halved
    assign halved.r = {1'b0, rd_pixel.r[2:1]};
    assign halved.g = {1'b0, rd_pixel.g[2:1]};
    assign halved.b = {1'b0, rd_pixel.b[2:1]};

    //////////////////////////////////////////////////
    // Bypass and vsync
    //////////////////////////////////////////////////

    always_ff @(posedge clk24) begin
        if (reset) begin
            byp_valid <= 1'b0;
            byp_hsync <= 1'b0;
            vsync     <= 1'b0;
        end else begin
            byp_valid <= pixel_ce;
            byp_hsync <= !hsync_n;
            // vsync is never doubled
            vsync     <= !vsync_n;
        end
    end

    always_ff @(posedge clk24) begin
        byp_pixel <= pixel;
    end

    // Output select by mode
    always_comb begin
        if (scan_enable) begin
            hsync     = in_sync;
            out_valid = in_active;
            pixel_out = (state == ACTIVE_PASS1 && scan_effect) ? halved : rd_pixel;
        end else begin
            hsync     = byp_hsync;
            out_valid = byp_valid;
            pixel_out = byp_pixel;
        end
    end

endmodule

/* source/line_buffer.sv */
`timescale 1ns/10ps

module line_buffer #(
    parameter int LINE_PIXELS = 32
) (
    input  logic                           clk24,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic [$clog2(LINE_PIXELS)-1:0] wr_addr,
    input  video_pkg::rgb_pixel_t          wr_pixel,
    input  logic                           line_done,
    input  logic [$clog2(LINE_PIXELS)-1:0] rd_addr,
    output video_pkg::rgb_pixel_t          rd_pixel
);
    import video_pkg::*;

    // Two banks side by side, bank bit on top of the address
    rgb_pixel_t mem [2*LINE_PIXELS];

    // Bank being written, the other one is read
    logic       bank_sel;

    always_ff @(posedge clk24) begin
        if (reset) begin
            bank_sel <= 1'b0;
        end else if (line_done) begin
            bank_sel <= !bank_sel;
        end
    end

    // Write port
    always_ff @(posedge clk24) begin
        if (wr_en) begin
            mem[{bank_sel, wr_addr}] <= wr_pixel;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk24) begin
        rd_pixel <= mem[{!bank_sel, rd_addr}];
    end

endmodule

/* source/pal_line_capture.sv */
`timescale 1ns/10ps

module pal_line_capture #(
    parameter int LINE_PIXELS = 32,
    parameter int VGA_HSYNC   = 4
) (
    input  logic                           clk24,
    input  logic                           reset,
    input  logic                           pixel_ce,
    input  logic                           hsync_n,
    input  video_pkg::rgb_pixel_t          pixel,
    output logic                           wr_en,
    output logic [$clog2(LINE_PIXELS)-1:0] wr_addr,
    output video_pkg::rgb_pixel_t          wr_pixel,
    output logic                           line_done
);
    import video_pkg::*;

    localparam int ADDR_W = $clog2(LINE_PIXELS);
    localparam int SYNC_W = $clog2(VGA_HSYNC + 1);

    capture_state_e    state;
    logic [SYNC_W-1:0] sync_count;
    logic [ADDR_W-1:0] pix_count;
    logic              take;

    // Sample to store this cycle
    // First high hsync_n sample is pixel 0
    assign take = pixel_ce && ((state == WAIT_ACTIVE && hsync_n) || state == ACTIVE);

    always_ff @(posedge clk24) begin
        if (reset) begin
            state      <= WAIT_SYNC;
            sync_count <= '0;
            pix_count  <= '0;
            wr_en      <= 1'b0;
            line_done  <= 1'b0;
        end else begin
            // Single-cycle strobes
            wr_en     <= 1'b0;
            line_done <= 1'b0;

            // Sync filter, needs VGA_HSYNC low samples in a row
            if (pixel_ce && state == WAIT_SYNC) begin
                if (hsync_n) begin
                    sync_count <= '0;
                end else if (sync_count == SYNC_W'(VGA_HSYNC - 1)) begin
                    sync_count <= '0;
                    state      <= WAIT_ACTIVE;
                end else begin
                    sync_count <= sync_count + 1'b1;
                end
            end

            if (take) begin
                wr_en     <= 1'b1;
                pix_count <= pix_count + 1'b1;
                state     <= ACTIVE;
                // Last stored pixel, the rest of the line is dropped
                if (pix_count == ADDR_W'(LINE_PIXELS - 1)) begin
                    line_done <= 1'b1;
                    state     <= WAIT_SYNC;
                end
            end
        end
    end

    // Write payload
    always_ff @(posedge clk24) begin
        if (take) begin
            wr_addr  <= pix_count;
            wr_pixel <= pixel;
        end
    end

endmodule

/* source/apb_ctrl_regs.sv */
`timescale 1ns/10ps

module apb_ctrl_regs (
    input  logic                clk24,
    input  logic                reset,
    input  video_pkg::apb_req_t apb_req,
    output video_pkg::apb_rsp_t apb_rsp,
    input  logic                line_done,
    output logic                scan_enable,
    output logic                scan_effect
);
    import video_pkg::*;

    // Control bits, both 0 after reset
    logic                   enable_scandoubling;
    logic                   disable_scaneffect;
    logic [LINES_WIDTH-1:0] line_count;

    // Response registers, loaded in the setup phase
    logic [31:0]            rdata_q;
    logic                   slverr_q;

    // Decode
    logic                   setup_phase;
    logic                   access_phase;
    reg_addr_e              addr;
    logic                   rd_ok;
    logic                   wr_ok;
    logic [31:0]            rd_value;

    assign setup_phase  = apb_req.psel && !apb_req.penable;
    assign access_phase = apb_req.psel && apb_req.penable;
    assign addr         = reg_addr_e'(apb_req.paddr);

    // Address decode and read mux
    always_comb begin
        rd_ok    = 1'b0;
        wr_ok    = 1'b0;
        rd_value = '0;
        case (addr)
            REG_CTRL: begin
                rd_ok = 1'b1;
                wr_ok = 1'b1;
                rd_value[CTRL_SCANDOUBLE_BIT] = enable_scandoubling;
                rd_value[CTRL_NO_EFFECT_BIT]  = disable_scaneffect;
            end
            // Counter is read only
            REG_LINES: begin
                rd_ok = 1'b1;
                rd_value[LINES_WIDTH-1:0] = line_count;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk24) begin
        if (reset) begin
            enable_scandoubling <= 1'b0;
            disable_scaneffect  <= 1'b0;
            line_count          <= '0;
            rdata_q             <= '0;
            slverr_q            <= 1'b0;
        end else begin
            // Response ready for the access phase
            if (setup_phase) begin
                rdata_q  <= apb_req.pwrite ? '0 : rd_value;
                slverr_q <= apb_req.pwrite ? !wr_ok : !rd_ok;
            end else if (access_phase) begin
                slverr_q <= 1'b0;
            end
            // Write takes effect at the end of the access phase
            if (access_phase && apb_req.pwrite && addr == REG_CTRL) begin
                enable_scandoubling <= apb_req.pwdata[CTRL_SCANDOUBLE_BIT];
                disable_scaneffect  <= apb_req.pwdata[CTRL_NO_EFFECT_BIT];
            end
            // Wraps at 16 bits
            if (line_done) begin
                line_count <= line_count + 1'b1;
            end
        end
    end

    // No wait states
    assign apb_rsp.prdata  = rdata_q;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = slverr_q;

    assign scan_enable = enable_scandoubling;
    assign scan_effect = !disable_scaneffect;

endmodule

/* source/video_pkg.sv */
package video_pkg;

    //////////////////////////////////////////////////
    // Video types
    //////////////////////////////////////////////////

    // One pixel, 3 bits per channel
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [2:0] b;
    } rgb_pixel_t;

    //////////////////////////////////////////////////
    // APB types and register map
    //////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register offsets
    typedef enum logic [3:0] {
        REG_CTRL  = 4'd0,
        REG_LINES = 4'd4
    } reg_addr_e;

    // REG_CTRL bit positions
    localparam int CTRL_SCANDOUBLE_BIT = 0;
    localparam int CTRL_NO_EFFECT_BIT  = 1;

    // Width of the captured-line counter
    localparam int LINES_WIDTH = 16;

    //////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        WAIT_SYNC,
        WAIT_ACTIVE,
        ACTIVE
    } capture_state_e;

    typedef enum logic [2:0] {
        IDLE,
        HSYNC_PASS0,
        ACTIVE_PASS0,
        HSYNC_PASS1,
        ACTIVE_PASS1
    } scan_state_e;

endpackage
